// ==== hdl/fx2_pkg.sv ====
/*
 * FX2 slave FIFO glue package
 * Shared byte and length types, framing constants, endpoint and packet
 * phase enums, and the status structs between endpoints and scheduler
 */
package fx2_pkg;

    // One byte on the FX2 FIFO data bus
    typedef logic [7:0] byte_t;

    // Packet length or running byte count
    typedef logic [15:0] length_t;

    // Every frame starts with this marker byte
    localparam byte_t HEADER_BYTE = 8'hFF;

    // Tracking FIFO write ports behind EP2
    localparam int NUM_DATA_PORTS = 4;

    // Idle cycles the sender tolerates from the encoder before closing a frame
    localparam int EP8_WAIT_CYCLES = 4;

    // Endpoint index, encoded as the FX2 FIFOADR value
    typedef enum logic [1:0] {
        EP2 = 2'd0,
        EP4 = 2'd1,
        EP8 = 2'd3
    } ep_index_e;

    // Packet phase, shared by the receive parser and the sender
    typedef enum logic [2:0] {
        WAITING,
        HEADER_ID,
        LENGTH_UPPER,
        LENGTH_LOWER,
        DATA,
        DONE
    } packet_state_e;

    // Frame header fields, id first to match the wire order
    typedef struct packed {
        byte_t   id;
        length_t length;
    } packet_header_t;

    // Receive path status toward the scheduler
    typedef struct packed {
        logic rd;       // Pop a byte from the selected FIFO this cycle
        logic yield;    // Packet left half done on an empty FIFO
        logic done;     // Visit finished
    } rx_status_t;

    // Transmit path status toward the scheduler
    typedef struct packed {
        logic pending;  // Encoder holds a command
        logic done;     // Visit finished
    } tx_status_t;

endpackage

// ==== hdl/endpoint_scheduler.sv ====
/*
 * Endpoint scheduler
 * Visits EP2, EP4 and EP8 in turn, jumping to EP8 whenever a command is
 * waiting, and turns the selected receiver's read request into SLRD
 */
`timescale 1ns/1ps

module endpoint_scheduler
    import fx2_pkg::*;
(
    input  logic       usb_ifclk,
    input  logic       reset,
    input  rx_status_t ep2_status,
    input  rx_status_t ep4_status,
    input  tx_status_t ep8_status,
    output ep_index_e  ep_index,
    output logic       usb_slrd
);

    logic visit_done;
    logic visit_yield;
    logic read_request;

    // Plain round-robin successor
    function automatic ep_index_e next_in_order(input ep_index_e current);
        ep_index_e next;
        case (current)
            EP2:     next = EP4;
            EP4:     next = EP8;
            default: next = EP2;
        endcase
        return next;
    endfunction

    // Pick the status of whichever endpoint owns the bus right now
    always_comb begin
        case (ep_index)
            EP2: begin
                visit_done   = ep2_status.done;
                visit_yield  = ep2_status.yield;
                read_request = ep2_status.rd;
            end
            EP4: begin
                visit_done   = ep4_status.done;
                visit_yield  = ep4_status.yield;
                read_request = ep4_status.rd;
            end
            default: begin
                // EP8 only writes, so it never requests a read
                visit_done   = ep8_status.done;
                visit_yield  = 1'b0;
                read_request = 1'b0;
            end
        endcase
    end

    // SLRD is active low and follows the request in the same cycle
    assign usb_slrd = ~read_request;

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            ep_index <= EP2;
        end else if (visit_done) begin
            // A waiting command jumps the queue after any finished visit
            if (ep8_status.pending) begin
                ep_index <= EP8;
            end else begin
                ep_index <= next_in_order(ep_index);
            end
        end else if (visit_yield) begin
            ep_index <= next_in_order(ep_index);
        end
    end

    // Only one receive path may pop the shared FIFO bus in a cycle
    assert property (@(posedge usb_ifclk) disable iff (reset)
        !(ep2_status.rd && ep4_status.rd))
        else $error("EP2 and EP4 requested a read in the same cycle");

endmodule

// ==== hdl/header_parser.sv ====
/*
 * Receive header parser
 * Tracks the frame phase of one OUT endpoint, captures the id and length,
 * and counts data bytes so a packet can be resumed after its endpoint is left
 */
`timescale 1ns/1ps

module header_parser
    import fx2_pkg::*;
(
    input  logic           usb_ifclk,
    input  logic           reset,
    input  logic           selected,
    input  logic           fifo_empty,
    input  logic           read_allowed,
    input  byte_t          usb_data_out,
    output packet_header_t header,
    output logic           in_data,
    output rx_status_t     status
);

    packet_state_e state;
    length_t       byte_count;
    logic          mid_packet;

    // Phases in which an empty FIFO means leaving the packet for later
    assign mid_packet = (state != WAITING) && (state != DONE);

    // Header bytes always flow and only the data phase waits on the consumer
    always_comb begin
        status.rd    = selected && !fifo_empty && (state != DONE)
                       && ((state != DATA) || read_allowed);
        status.yield = selected && fifo_empty && mid_packet;
        status.done  = selected && (state == DONE);
    end

    assign in_data = selected && (state == DATA);

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            state <= WAITING;
        end else begin
            case (state)
                WAITING: begin
                    // Anything but a marker, or nothing at all, ends the visit
                    if (status.rd && usb_data_out == HEADER_BYTE) begin
                        state <= HEADER_ID;
                    end else if (selected) begin
                        state <= DONE;
                    end
                end
                HEADER_ID: begin
                    if (status.rd) begin
                        state <= LENGTH_UPPER;
                    end
                end
                LENGTH_UPPER: begin
                    if (status.rd) begin
                        state <= LENGTH_LOWER;
                    end
                end
                LENGTH_LOWER: begin
                    if (status.rd) begin
                        // An empty packet has nothing to read after the header
                        if ({header.length[15:8], usb_data_out} == '0) begin
                            state <= DONE;
                        end else begin
                            state <= DATA;
                        end
                    end
                end
                DATA: begin
                    if (status.rd && byte_count == header.length - 1'b1) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= WAITING;
                end
            endcase
        end
    end

    // Header fields and byte count load only on popped bytes
    always_ff @(posedge usb_ifclk) begin
        if (status.rd) begin
            case (state)
                HEADER_ID:    header.id           <= usb_data_out;
                LENGTH_UPPER: header.length[15:8] <= usb_data_out;
                LENGTH_LOWER: begin
                    header.length[7:0] <= usb_data_out;
                    byte_count         <= '0;
                end
                DATA:         byte_count <= byte_count + 1'b1;
                default:      ;
            endcase
        end
    end

    // The count stays below the declared length for the whole data phase
    assert property (@(posedge usb_ifclk) disable iff (reset)
        (state == DATA) |-> (byte_count < header.length))
        else $error("Byte counter passed the packet length");

endmodule

// ==== hdl/ep2_data_receiver.sv ====
/*
 * EP2 data receiver
 * Parses framed data packets and steers each data byte to the tracking FIFO
 * write port named by the header id
 */
`timescale 1ns/1ps

module ep2_data_receiver
    import fx2_pkg::*;
(
    input  logic                      usb_ifclk,
    input  logic                      reset,
    input  logic                      selected,
    input  logic                      usb_ep2_empty,
    input  byte_t                     usb_data_out,
    output logic [NUM_DATA_PORTS-1:0] ep2_port_write,
    output rx_status_t                status
);

    packet_header_t header;
    logic           in_data;

    // Data bytes are never held back on this path
    header_parser u_parser (
        .usb_ifclk    (usb_ifclk),
        .reset        (reset),
        .selected     (selected),
        .fifo_empty   (usb_ep2_empty),
        .read_allowed (1'b1),
        .usb_data_out (usb_data_out),
        .header       (header),
        .in_data      (in_data),
        .status       (status)
    );

    // One-hot strobe on bytes actually popped; out-of-range ids fall on the floor
    always_comb begin
        for (int i = 0; i < NUM_DATA_PORTS; i++) begin
            ep2_port_write[i] = in_data && status.rd && (header.id == byte_t'(i));
        end
    end

endmodule

// ==== hdl/ep4_command_receiver.sv ====
/*
 * EP4 command receiver
 * Parses framed command packets, shows the header to the command decoder
 * and lets the decoder pace the data reads
 */
`timescale 1ns/1ps

module ep4_command_receiver
    import fx2_pkg::*;
(
    input  logic           usb_ifclk,
    input  logic           reset,
    input  logic           selected,
    input  logic           usb_ep4_empty,
    input  byte_t          usb_data_out,
    input  logic           cmd_in_read,
    output packet_header_t cmd_in_header,
    output logic           cmd_in_ready,
    output rx_status_t     status
)
;

    logic in_data;

    // The decoder's read line gates the data phase, so a slow decoder
    // stalls the endpoint instead of making it yield
    header_parser u_parser (
        .usb_ifclk    (usb_ifclk),
        .reset        (reset),
        .selected     (selected),
        .fifo_empty   (usb_ep4_empty),
        .read_allowed (cmd_in_read),
        .usb_data_out (usb_data_out),
        .header       (cmd_in_header),
        .in_data      (in_data),
        .status       (status)
    );

    // Ready spans the whole data phase while EP4 holds the bus
    assign cmd_in_ready = in_data;

endmodule

// ==== hdl/ep8_command_sender.sv ====
/*
 * EP8 command sender
 * Frames a pending encoder command as marker, id and length, then writes
 * the data bytes the encoder offers, giving up after a run of idle cycles
 */
`timescale 1ns/1ps

module ep8_command_sender
    import fx2_pkg::*;
(
    input  logic           usb_ifclk,
    input  logic           reset,
    input  logic           selected,
    input  logic           usb_ep8_full,
    input  packet_header_t cmd_out_header,
    input  byte_t          cmd_out_data,
    input  logic           cmd_out_write,
    output logic           cmd_out_ready,
    output logic           usb_slwr,
    output byte_t          usb_data_in,
    output tx_status_t     status
);

    packet_state_e                        state;
    length_t                              frame_length;
    length_t                              byte_count;
    logic [$clog2(EP8_WAIT_CYCLES+1)-1:0] idle_count;

    // A zero id means the encoder has nothing to say
    assign status.pending = (cmd_out_header.id != '0);
    assign status.done    = selected && (state == DONE);
    assign cmd_out_ready  = selected && (state == DATA);

    always_ff @(posedge usb_ifclk) begin
        if (reset) begin
            state    <= WAITING;
            usb_slwr <= 1'b1;
        end else begin
            // SLWR is a one-cycle strobe unless a branch below writes
            usb_slwr <= 1'b1;
            case (state)
                WAITING: begin
                    if (selected && status.pending && !usb_ep8_full) begin
                        usb_slwr     <= 1'b0;
                        usb_data_in  <= HEADER_BYTE;
                        frame_length <= cmd_out_header.length;
                        state        <= HEADER_ID;
                    end else if (selected) begin
                        // Nothing to send or no room, try again next visit
                        state <= DONE;
                    end
                end
                HEADER_ID: begin
                    usb_slwr    <= 1'b0;
                    usb_data_in <= cmd_out_header.id;
                    state       <= LENGTH_UPPER;
                end
                LENGTH_UPPER: begin
                    usb_slwr    <= 1'b0;
                    usb_data_in <= frame_length[15:8];
                    state       <= LENGTH_LOWER;
                end
                LENGTH_LOWER: begin
                    usb_slwr    <= 1'b0;
                    usb_data_in <= frame_length[7:0];
                    byte_count  <= '0;
                    idle_count  <= '0;
                    // Empty command ends right after the header
                    state       <= (frame_length == '0) ? DONE : DATA;
                end
                DATA: begin
                    if (cmd_out_write) begin
                        usb_slwr    <= 1'b0;
                        usb_data_in <= cmd_out_data;
                        byte_count  <= byte_count + 1'b1;
                        idle_count  <= '0;
                        if (byte_count == frame_length - 1'b1) begin
                            state <= DONE;
                        end
                    end else begin
                        idle_count <= idle_count + 1'b1;
                        // Encoder went quiet for too long
                        if (idle_count == ($bits(idle_count))'(EP8_WAIT_CYCLES - 1)) begin
                            state <= DONE;
                        end
                    end
                end
                default: begin
                    state <= WAITING;
                end
            endcase
        end
    end

    // Writes land in EP8 only, so the bus must still point there
    assert property (@(posedge usb_ifclk) disable iff (reset)
        !usb_slwr |-> selected)
        else $error("SLWR asserted while EP8 is not selected");

endmodule

// ==== hdl/fx2_interface.sv ====
/*
 * FX2 interface top level
 * Connects the endpoint scheduler, the EP2 data receiver, the EP4 command
 * receiver and the EP8 command sender to the FX2 slave FIFO pins
 */
`timescale 1ns/1ps

module fx2_interface
    import fx2_pkg::*;
(
    input  logic                      usb_ifclk,
    input  logic                      reset,
    input  byte_t                     usb_data_out,
    input  logic                      usb_ep2_empty,
    input  logic                      usb_ep4_empty,
    input  logic                      usb_ep8_full,
    output ep_index_e                 usb_addr,
    output logic                      usb_slrd,
    output logic                      usb_slwr,
    output logic                      usb_sloe,
    output byte_t                     usb_data_in,
    output byte_t                     ep2_port_data,
    output logic [NUM_DATA_PORTS-1:0] ep2_port_write,
    output packet_header_t            cmd_in_header,
    output byte_t                     cmd_in_data,
    output logic                      cmd_in_ready,
    input  logic                      cmd_in_read,
    input  packet_header_t            cmd_out_header,
    input  byte_t                     cmd_out_data,
    input  logic                      cmd_out_write,
    output logic                      cmd_out_ready
);

    rx_status_t ep2_status;
    rx_status_t ep4_status;
    tx_status_t ep8_status;

    // Endpoint selects decoded from the scheduler's current index
    wire ep2_selected = (usb_addr == EP2);
    wire ep4_selected = (usb_addr == EP4);
    wire ep8_selected = (usb_addr == EP8);

    // The FX2 always drives its data bus toward us
    assign usb_sloe = 1'b0;

    // Both consumers see the FIFO byte directly and qualify it with their strobes
    assign ep2_port_data = usb_data_out;
    assign cmd_in_data   = usb_data_out;

    endpoint_scheduler u_scheduler (
        .usb_ifclk  (usb_ifclk),
        .reset      (reset),
        .ep2_status (ep2_status),
        .ep4_status (ep4_status),
        .ep8_status (ep8_status),
        .ep_index   (usb_addr),
        .usb_slrd   (usb_slrd)
    );

    ep2_data_receiver u_ep2 (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .selected       (ep2_selected),
        .usb_ep2_empty  (usb_ep2_empty),
        .usb_data_out   (usb_data_out),
        .ep2_port_write (ep2_port_write),
        .status         (ep2_status)
    );

    ep4_command_receiver u_ep4 (
        .usb_ifclk     (usb_ifclk),
        .reset         (reset),
        .selected      (ep4_selected),
        .usb_ep4_empty (usb_ep4_empty),
        .usb_data_out  (usb_data_out),
        .cmd_in_read   (cmd_in_read),
        .cmd_in_header (cmd_in_header),
        .cmd_in_ready  (cmd_in_ready),
        .status        (ep4_status)
    );

    ep8_command_sender u_ep8 (
        .usb_ifclk      (usb_ifclk),
        .reset          (reset),
        .selected       (ep8_selected),
        .usb_ep8_full   (usb_ep8_full),
        .cmd_out_header (cmd_out_header),
        .cmd_out_data   (cmd_out_data),
        .cmd_out_write  (cmd_out_write),
        .cmd_out_ready  (cmd_out_ready),
        .usb_slwr       (usb_slwr),
        .usb_data_in    (usb_data_in),
        .status         (ep8_status)
    );

endmodule

// ==== verification/fx2_interface_tb.sv ====
/*
 * FX2 interface testbench
 * Models the FX2 slave FIFOs, the command decoder and the command encoder,
 * and runs directed EP2, EP4 and EP8 transfers against the DUT
 */
`timescale 1ns/1ps

module fx2_interface_tb
    import fx2_pkg::*;
();

    logic                      usb_ifclk;
    logic                      reset;
    byte_t                     usb_data_out;
    logic                      usb_ep2_empty;
    logic                      usb_ep4_empty;
    logic                      usb_ep8_full;
    ep_index_e                 usb_addr;
    logic                      usb_slrd;
    logic                      usb_slwr;
    logic                      usb_sloe;
    byte_t                     usb_data_in;
    byte_t                     ep2_port_data;
    logic [NUM_DATA_PORTS-1:0] ep2_port_write;
    packet_header_t            cmd_in_header;
    byte_t                     cmd_in_data;
    logic                      cmd_in_ready;
    logic                      cmd_in_read;
    packet_header_t            cmd_out_header;
    byte_t                     cmd_out_data;
    logic                      cmd_out_write;
    logic                      cmd_out_ready;

    // FX2 FIFO contents, plus what the DUT handed to the EP2 ports and the decoder
    byte_t                     ep2_q[$];
    byte_t                     ep4_q[$];
    byte_t                     ep8_q[$];
    byte_t                     ep2_seen_data[$];
    logic [NUM_DATA_PORTS-1:0] ep2_seen_strobe[$];
    byte_t                     ep4_seen[$];
    byte_t                     popped;
    logic [15:0]               lfsr;
    logic                      pace_reads;

    fx2_interface DUT (.*);

    initial begin
        usb_ifclk = 1'b0;
        forever #10 usb_ifclk = ~usb_ifclk;
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11
    function automatic logic next_random_bit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic byte_t random_byte();
        byte_t value;
        value = '0;
        for (int i = 0; i < 8; i++) begin
            value = {value[6:0], next_random_bit()};
        end
        return value;
    endfunction

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare_byte(input string what, input byte_t got, input byte_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %02h, expected %02h",
                                    $time, what, got, expected));
        end
    endtask

    task automatic compare_length(input string what, input length_t got,
                                  input length_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %0d, expected %0d",
                                    $time, what, got, expected));
        end
    endtask

    task automatic compare_header(input string what, input packet_header_t got,
                                  input packet_header_t expected);
        if (got !== expected) begin
            stop_on_error($sformatf(
                "Mismatch at %0t ns: %s is id %02h len %0d, expected id %02h len %0d",
                $time, what, got.id, got.length, expected.id, expected.length));
        end
    endtask

    task automatic compare_strobe(input string what, input logic [NUM_DATA_PORTS-1:0] got,
                                  input logic [NUM_DATA_PORTS-1:0] expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                    $time, what, got, expected));
        end
    endtask

    task automatic compare_level(input string what, input logic got, input logic expected);
        if (got !== expected) begin
            stop_on_error($sformatf("Mismatch at %0t ns: %s is %b, expected %b",
                                    $time, what, got, expected));
        end
    endtask

    // Queues load 1 ns after the edge, inputs move at 2 ns, checks look at 3 ns
    task automatic load_slot();
        @(posedge usb_ifclk);
        #1;
    endtask

    task automatic drive_slot();
        @(posedge usb_ifclk);
        #2;
    endtask

    task automatic sample_slot();
        @(posedge usb_ifclk);
        #3;
    endtask

    // FIFO flags and the front byte of whichever FIFO the address selects
    task automatic update_fifo_pins();
        usb_ep2_empty = (ep2_q.size() == 0);
        usb_ep4_empty = (ep4_q.size() == 0);
        usb_ep8_full  = 1'b0;
        if (usb_addr == EP2 && ep2_q.size() > 0) begin
            usb_data_out = ep2_q[0];
        end else if (usb_addr == EP4 && ep4_q.size() > 0) begin
            usb_data_out = ep4_q[0];
        end else begin
            usb_data_out = '0;
        end
    endtask

    // The FX2 model records the DUT's consumers and strobes on the pre-edge values
    always @(posedge usb_ifclk) begin
        if (ep2_port_write != '0) begin
            ep2_seen_strobe.push_back(ep2_port_write);
            ep2_seen_data.push_back(ep2_port_data);
        end
        // A decoder byte moves only when ready, asked for and present
        if (cmd_in_ready && cmd_in_read && !usb_ep4_empty) begin
            ep4_seen.push_back(cmd_in_data);
        end
        if (usb_slrd === 1'b0) begin
            if (usb_addr == EP2 && ep2_q.size() > 0) begin
                popped = ep2_q.pop_front();
            end else if (usb_addr == EP4 && ep4_q.size() > 0) begin
                popped = ep4_q.pop_front();
            end else begin
                stop_on_error("The DUT pulsed SLRD on an empty or write-only FIFO");
            end
        end
        if (usb_slwr === 1'b0) begin
            ep8_q.push_back(usb_data_in);
        end
        #2;
        update_fifo_pins();
    end

    // Decoder stand-in that accepts bytes on random cycles
    always @(posedge usb_ifclk) begin
        #2;
        cmd_in_read = pace_reads ? next_random_bit() : 1'b0;
    end

    // The scheduler leaves EP8 and comes back, so a whole rotation has passed
    task automatic wait_for_ep8_revisit();
        logic left_ep8;
        int   cycles;
        left_ep8 = 1'b0;
        cycles   = 0;
        while (!(left_ep8 && usb_addr == EP8)) begin
            sample_slot();
            if (usb_addr != EP8) begin
                left_ep8 = 1'b1;
            end
            cycles++;
            if (cycles > 200) begin
                stop_on_error("Timed out waiting for the scheduler to return to EP8");
            end
        end
    endtask

    task automatic check_reset_state();
        compare_level("usb_slwr in reset", usb_slwr, 1'b1);
        compare_level("usb_slrd in reset", usb_slrd, 1'b1);
        compare_level("usb_sloe", usb_sloe, 1'b0);
        compare_strobe("ep2_port_write in reset", ep2_port_write, '0);
        compare_level("cmd_in_ready in reset", cmd_in_ready, 1'b0);
        compare_level("cmd_out_ready in reset", cmd_out_ready, 1'b0);
        compare_level("usb_addr is EP2 in reset", usb_addr == EP2, 1'b1);
    endtask

    // One framed EP2 packet, optionally behind a stray byte that must be dropped
    task automatic send_ep2_packet(input byte_t port, input length_t len, input logic junk);
        byte_t                     data[$];
        byte_t                     value;
        logic [NUM_DATA_PORTS-1:0] expected_strobe;
        int                        cycles;
        load_slot();
        ep2_seen_strobe.delete();
        ep2_seen_data.delete();
        if (junk) begin
            ep2_q.push_back(8'h3C);
        end
        ep2_q.push_back(HEADER_BYTE);
        ep2_q.push_back(port);
        ep2_q.push_back(len[15:8]);
        ep2_q.push_back(len[7:0]);
        for (int i = 0; i < len; i++) begin
            value = random_byte();
            data.push_back(value);
            ep2_q.push_back(value);
        end
        cycles = 0;
        while (ep2_q.size() != 0) begin
            sample_slot();
            cycles++;
            if (cycles > 1000) begin
                stop_on_error("Timed out waiting for the DUT to drain the EP2 FIFO");
            end
        end
        expected_strobe       = '0;
        expected_strobe[port] = 1'b1;
        compare_length("EP2 write strobe count", length_t'(ep2_seen_strobe.size()), len);
        for (int i = 0; i < len; i++) begin
            compare_strobe("ep2_port_write", ep2_seen_strobe[i], expected_strobe);
            compare_byte("ep2_port_data", ep2_seen_data[i], data[i]);
        end
    endtask

    task automatic send_ep4_command(input byte_t id, input length_t len);
        byte_t          data[$];
        byte_t          value;
        packet_header_t expected_header;
        logic           seen_ready;
        int             cycles;
        load_slot();
        ep4_seen.delete();
        expected_header = {id, len};
        ep4_q.push_back(HEADER_BYTE);
        ep4_q.push_back(id);
        ep4_q.push_back(len[15:8]);
        ep4_q.push_back(len[7:0]);
        for (int i = 0; i < len; i++) begin
            value = random_byte();
            data.push_back(value);
            ep4_q.push_back(value);
        end
        pace_reads = 1'b1;
        seen_ready = 1'b0;
        cycles     = 0;
        while (ep4_q.size() != 0) begin
            sample_slot();
            if (cmd_in_ready) begin
                seen_ready = 1'b1;
                compare_header("cmd_in_header", cmd_in_header, expected_header);
            end
            cycles++;
            if (cycles > 2000) begin
                stop_on_error("Timed out waiting for the decoder to read the EP4 command");
            end
        end
        pace_reads = 1'b0;
        if (!seen_ready) begin
            stop_on_error("cmd_in_ready never rose during the EP4 command");
        end
        compare_length("EP4 bytes delivered", length_t'(ep4_seen.size()), len);
        for (int i = 0; i < len; i++) begin
            compare_byte("cmd_in_data", ep4_seen[i], data[i]);
        end
    endtask

    // Encoder stand-in offers a byte on every cycle that the sender is ready
    task automatic send_ep8_command(input byte_t id, input length_t len);
        byte_t data[$];
        int    sent;
        int    cycles;
        load_slot();
        ep8_q.delete();
        for (int i = 0; i < len; i++) begin
            data.push_back(random_byte());
        end
        drive_slot();
        cmd_out_header = {id, len};
        sent   = 0;
        cycles = 0;
        while (sent < len) begin
            drive_slot();
            cmd_out_write = cmd_out_ready;
            if (cmd_out_ready) begin
                cmd_out_data = data[sent];
                sent++;
                // The last byte is on the bus, so the command is no longer pending
                if (sent == len) begin
                    cmd_out_header = '0;
                end
            end
            cycles++;
            if (cycles > 1000) begin
                stop_on_error("Timed out waiting for the EP8 sender to take the command");
            end
        end
        drive_slot();
        cmd_out_write = 1'b0;
        // The frame is complete once the sender has let go of EP8 for a full turn
        wait_for_ep8_revisit();
        compare_length("EP8 bytes written", length_t'(ep8_q.size()), len + 4);
        compare_byte("EP8 marker", ep8_q[0], HEADER_BYTE);
        compare_byte("EP8 id", ep8_q[1], id);
        compare_byte("EP8 length upper", ep8_q[2], len[15:8]);
        compare_byte("EP8 length lower", ep8_q[3], len[7:0]);
        for (int i = 0; i < len; i++) begin
            compare_byte("EP8 data", ep8_q[4 + i], data[i]);
        end
    endtask

    // The encoder stays silent, so the sender gives up after the header
    task automatic check_ep8_idle_timeout(input byte_t id, input length_t len);
        logic seen_ready;
        int   cycles;
        load_slot();
        ep8_q.delete();
        drive_slot();
        cmd_out_header = {id, len};
        seen_ready     = 1'b0;
        cycles         = 0;
        while (!(seen_ready && !cmd_out_ready)) begin
            drive_slot();
            if (cmd_out_ready) begin
                seen_ready = 1'b1;
            end
            cycles++;
            if (cycles > 200) begin
                stop_on_error("Timed out waiting for cmd_out_ready to rise and fall");
            end
        end
        cmd_out_header = '0;
        // Let a full rotation pass to show nothing else reaches EP8
        wait_for_ep8_revisit();
        compare_length("EP8 bytes after idle timeout", length_t'(ep8_q.size()), 16'd4);
        compare_byte("EP8 marker", ep8_q[0], HEADER_BYTE);
        compare_byte("EP8 id", ep8_q[1], id);
        compare_byte("EP8 length upper", ep8_q[2], len[15:8]);
        compare_byte("EP8 length lower", ep8_q[3], len[7:0]);
    endtask

    initial begin
        lfsr           = 16'd66;
        pace_reads     = 1'b0;
        reset          = 1'b1;
        cmd_in_read    = 1'b0;
        cmd_out_header = '0;
        cmd_out_data   = '0;
        cmd_out_write  = 1'b0;
        update_fifo_pins();
        repeat (5) @(posedge usb_ifclk);
        #1;
        check_reset_state();
        #1;
        reset = 1'b0;
        for (int k = 0; k < NUM_DATA_PORTS; k++) begin
            send_ep2_packet(byte_t'(k), length_t'(3 + 2 * k), 1'b0);
        end
        send_ep2_packet(8'd2, 16'd6, 1'b1);
        send_ep4_command(8'h21, 16'd12);
        send_ep8_command(8'h35, 16'd7);
        check_ep8_idle_timeout(8'h47, 16'd5);
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/fx2_pkg.sv
hdl/endpoint_scheduler.sv
hdl/header_parser.sv
hdl/ep2_data_receiver.sv
hdl/ep4_command_receiver.sv
hdl/ep8_command_sender.sv
hdl/fx2_interface.sv
verification/fx2_interface_tb.sv
